// File: mmio_soc.f
+incdir+.
soc_pkg.sv
region_decode.sv
ram_bank.sv
sector_buffer.sv
periph_regs.sv
read_return.sv
mmio_soc.sv
tb_mmio_soc.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    -f mmio_soc.f \
    --top-module tb_mmio_soc \
    -o Vtb_mmio_soc

./obj_dir/Vtb_mmio_soc > sim.log
cat sim.log

if grep -q "Simulation PASSED" sim.log; then
    exit 0
else
    exit 1
fi

// File: mmio_model.svh
`ifndef MMIO_MODEL_SVH
`define MMIO_MODEL_SVH

// Reference state of the memory-mapped side
logic [31:0] ram_model [RAM_WORDS_DEFAULT];
int          written_idx [$];
byte_t       key_model;
byte_t       sector_model [SECTOR_BYTES_DEFAULT];

// Expected read data and the cycle its done is due
data_t exp_q [$];
int    due_q [$];

int mismatch_errs;
int protocol_errs;

task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
        mismatch_errs++;
        $display("mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
endtask

task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (act !== exp) begin
        mismatch_errs++;
        $display("mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
endtask

task automatic check_irq(input string name, input irq_vec_t exp, input irq_vec_t act);
    if (act !== exp) begin
        mismatch_errs++;
        $display("mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
endtask

task automatic check_byte(input string name, input byte_t exp, input byte_t act);
    if (act !== exp) begin
        mismatch_errs++;
        $display("mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        mismatch_errs++;
        $display("mismatch at %0t: %s expected %b, got %b", $time, name, exp, act);
    end
endtask

// Expected answer of an address outside the sector buffer
function automatic data_t model_read(input addr_t addr);
    addr_t off;
    off = addr - RAM_BASE;
    if (addr >= RAM_BASE && addr < RAM_BASE + 32'(RAM_WORDS_DEFAULT * 4)) begin
        return {32'd0, ram_model[off[11:2]]};
    end
    if (addr == KEY_ADDR) begin
        return {56'd0, key_model};
    end
    return '0;
endfunction

`endif

// File: tb_mmio_soc.sv
module tb_mmio_soc
    import soc_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 20000;

    logic     CLOCK_50;
    logic     KEY0;
    addr_t    bus_address;
    data_t    bus_write_data;
    logic     bus_write_enable;
    logic     bus_read_enable;
    data_t    bus_read_data;
    logic     bus_read_done;
    byte_t    key_code;
    logic     key_valid;
    logic     irq_ack;
    irq_vec_t irq_vector;
    byte_t    uart_data;
    logic     uart_valid;
    logic     uart_ready;
    addr_t    sd_sector;
    logic     sd_read_start;
    byte_t    sd_byte;
    logic     sd_byte_valid;
    logic     sd_byte_ready;

    logic [31:0] lfsr = 32'hd6c9;
    int          cyc = 0;

    `include "mmio_model.svh"

    mmio_soc i_mmio_soc (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .bus_read_enable  (bus_read_enable),
        .bus_read_data    (bus_read_data),
        .bus_read_done    (bus_read_done),
        .key_code         (key_code),
        .key_valid        (key_valid),
        .irq_ack          (irq_ack),
        .irq_vector       (irq_vector),
        .uart_data        (uart_data),
        .uart_valid       (uart_valid),
        .uart_ready       (uart_ready),
        .sd_sector        (sd_sector),
        .sd_read_start    (sd_read_start),
        .sd_byte          (sd_byte),
        .sd_byte_valid    (sd_byte_valid),
        .sd_byte_ready    (sd_byte_ready)
    );

    always #10 CLOCK_50 = ~CLOCK_50;

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    always @(posedge CLOCK_50) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // Read tracking, sampled away from the active edge
    always @(negedge CLOCK_50) begin
        if (bus_read_done) begin
            if (exp_q.size() == 0) begin
                protocol_errs++;
                $display("read done at %0t with no read outstanding", $time);
            end else begin
                if (due_q[0] != cyc) begin
                    protocol_errs++;
                    $display("read done at %0t came in cycle %0d, expected cycle %0d",
                             $time, cyc, due_q[0]);
                end
                check_data("bus_read_data", exp_q[0], bus_read_data);
                void'(exp_q.pop_front());
                void'(due_q.pop_front());
            end
        end else if (due_q.size() != 0 && due_q[0] <= cyc) begin
            protocol_errs++;
            $display("read done missing at %0t for the read due in cycle %0d", $time, due_q[0]);
            void'(exp_q.pop_front());
            void'(due_q.pop_front());
        end
    end

    task automatic bus_write(input addr_t addr, input data_t data);
        @(posedge CLOCK_50);
        bus_address      <= addr;
        bus_write_data   <= data;
        bus_write_enable <= 1'b1;
        bus_read_enable  <= 1'b0;
    endtask

    task automatic bus_read(input addr_t addr, input data_t exp);
        @(posedge CLOCK_50);
        bus_address      <= addr;
        bus_write_enable <= 1'b0;
        bus_read_enable  <= 1'b1;
        exp_q.push_back(exp);
        due_q.push_back(cyc + 3);
    endtask

    task automatic bus_idle();
        @(posedge CLOCK_50);
        bus_write_enable <= 1'b0;
        bus_read_enable  <= 1'b0;
    endtask

    task automatic drain_reads();
        while (exp_q.size() != 0) begin
            @(negedge CLOCK_50);
        end
    endtask

    task automatic ram_phase();
        logic [9:0] idx;
        data_t      data;
        for (int i = 0; i < 300; i++) begin
            idx  = 10'(rand_bits(10));
            data = {rand_bits(32), rand_bits(32)};
            ram_model[idx] = data[31:0];
            written_idx.push_back(int'(idx));
            bus_write(RAM_BASE + {20'd0, idx, 2'b00}, data);
        end
        // Back-to-back reads of words that hold data
        for (int i = 0; i < 300; i++) begin
            idx = 10'(written_idx[rand_bits(16) % written_idx.size()]);
            bus_read(RAM_BASE + {20'd0, idx, 2'b00}, {32'd0, ram_model[idx]});
        end
        bus_idle();
        drain_reads();
    endtask

    task automatic unmapped_phase();
        addr_t holes [6];
        int    k;
        holes = '{32'h0000_0000, 32'h0000_2000, 32'h4000_0000,
                  32'h8000_2000, 32'h8000_0030, 32'h8000_0800};
        foreach (holes[i]) begin
            bus_read(holes[i], '0);
            bus_write(holes[i], {rand_bits(32), rand_bits(32)});
        end
        foreach (holes[i]) begin
            bus_read(holes[i], '0);
        end
        for (int i = 0; i < 5; i++) begin
            k = written_idx[i];
            bus_read(RAM_BASE + 32'(k * 4), model_read(RAM_BASE + 32'(k * 4)));
        end
        bus_idle();
        drain_reads();
    endtask

    task automatic key_phase();
        byte_t code;
        for (int i = 0; i < 20; i++) begin
            code = byte_t'(rand_bits(8));
            if (i % 5 == 0) begin
                code = '0;
            end
            @(posedge CLOCK_50);
            key_code  <= code;
            key_valid <= 1'b1;
            @(posedge CLOCK_50);
            @(negedge CLOCK_50);
            if (code != '0) begin
                key_model = code;
            end
            check_irq("irq_vector", (code != '0) ? irq_vec_t'(1) : irq_vec_t'(0), irq_vector);
            // Key still held here, so no new interrupt
            bus_read(KEY_ADDR, model_read(KEY_ADDR));
            bus_idle();
            @(posedge CLOCK_50);
            irq_ack <= 1'b1;
            @(posedge CLOCK_50);
            irq_ack   <= 1'b0;
            key_valid <= 1'b0;
            @(negedge CLOCK_50);
            check_irq("irq_vector", irq_vec_t'(0), irq_vector);
        end
        drain_reads();
    endtask

    task automatic uart_phase();
        logic  valid_m;
        byte_t data_m;
        logic  wr_d;
        logic  rdy_d;
        byte_t byte_d;
        valid_m = 1'b0;
        data_m  = '0;
        wr_d    = 1'b0;
        rdy_d   = 1'b0;
        byte_d  = '0;
        for (int i = 0; i < 200; i++) begin
            @(posedge CLOCK_50);
            // Apply what the DUT sampled at this edge
            if (wr_d && !valid_m) begin
                valid_m = 1'b1;
                data_m  = byte_d;
            end else if (valid_m && rdy_d) begin
                valid_m = 1'b0;
            end
            wr_d   = (rand_bits(1) != 32'd0);
            rdy_d  = rand_bits(2) == 32'd0;
            byte_d = byte_t'(rand_bits(8));
            bus_address      <= UART_ADDR;
            bus_write_data   <= {56'd0, byte_d};
            bus_write_enable <= wr_d;
            uart_ready       <= rdy_d;
            @(negedge CLOCK_50);
            check_flag("uart_valid", valid_m, uart_valid);
            if (valid_m) begin
                check_byte("uart_data", data_m, uart_data);
            end
        end
        bus_idle();
        uart_ready <= 1'b1;
    endtask

    task automatic sector_phase();
        data_t sec;
        int    idx;
        logic  drove;
        sec = {rand_bits(32), rand_bits(32)};
        bus_write(SD_ADDR_REG, sec);
        bus_idle();
        @(negedge CLOCK_50);
        check_addr("sd_sector", sec[31:0], sd_sector);
        bus_read(SD_ADDR_REG, {32'd0, sec[31:0]});
        foreach (sector_model[i]) begin
            sector_model[i] = byte_t'(rand_bits(8));
        end
        bus_write(SD_READ_REG, '0);
        bus_idle();
        // Start pulse and ready one edge after the write
        @(negedge CLOCK_50);
        check_flag("sd_read_start", 1'b1, sd_read_start);
        check_flag("sd_byte_ready", 1'b1, sd_byte_ready);
        idx   = 0;
        drove = 1'b0;
        for (int c = 0; idx < SECTOR_BYTES_DEFAULT; c++) begin
            @(posedge CLOCK_50);
            // Buffer stays ready until the last byte, so every offered byte is taken
            if (drove) begin
                idx++;
            end
            drove = (idx < SECTOR_BYTES_DEFAULT) && (rand_bits(2) != 32'd0);
            sd_byte_valid <= drove;
            sd_byte       <= sector_model[idx % SECTOR_BYTES_DEFAULT];
            // Poll the full flag while the fill is well short of the end
            if (c % 64 == 0 && idx < 500) begin
                bus_address     <= SD_AVAIL_REG;
                bus_read_enable <= 1'b1;
                exp_q.push_back('0);
                due_q.push_back(cyc + 3);
            end else begin
                bus_read_enable <= 1'b0;
            end
            @(negedge CLOCK_50);
            check_flag("sd_read_start", 1'b0, sd_read_start);
            check_flag("sd_byte_ready", idx < SECTOR_BYTES_DEFAULT, sd_byte_ready);
        end
        bus_idle();
        bus_read(SD_AVAIL_REG, 64'd1);
        for (int i = 0; i < SECTOR_BYTES_DEFAULT; i++) begin
            bus_read(SD_BUF_BASE + 32'(i), {56'd0, sector_model[i]});
        end
        bus_idle();
        drain_reads();
    endtask

    initial begin
        CLOCK_50         = 1'b0;
        KEY0             = 1'b0;
        bus_address      = '0;
        bus_write_data   = '0;
        bus_write_enable = 1'b0;
        bus_read_enable  = 1'b0;
        key_code         = '0;
        key_valid        = 1'b0;
        irq_ack          = 1'b0;
        uart_ready       = 1'b0;
        sd_byte          = '0;
        sd_byte_valid    = 1'b0;
        key_model        = '0;
        mismatch_errs    = 0;
        protocol_errs    = 0;
        repeat (3) @(posedge CLOCK_50);
        KEY0 <= 1'b1;
        repeat (2) @(posedge CLOCK_50);

        ram_phase();
        // Key latch holds a code before the holes that alias it are read
        key_phase();
        unmapped_phase();
        uart_phase();
        sector_phase();
        repeat (5) @(posedge CLOCK_50);

        $display("errors: %0d mismatch, %0d protocol", mismatch_errs, protocol_errs);
        if (mismatch_errs == 0 && protocol_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: mmio_soc.sv
module mmio_soc
    import soc_pkg::*;
#(
    parameter int RAM_WORDS    = RAM_WORDS_DEFAULT,
    parameter int SECTOR_BYTES = SECTOR_BYTES_DEFAULT
) (
    input  logic     CLOCK_50,
    input  logic     KEY0,
    input  addr_t    bus_address,
    input  data_t    bus_write_data,
    input  logic     bus_write_enable,
    input  logic     bus_read_enable,
    output data_t    bus_read_data,
    output logic     bus_read_done,
    input  byte_t    key_code,
    input  logic     key_valid,
    input  logic     irq_ack,
    output irq_vec_t irq_vector,
    output byte_t    uart_data,
    output logic     uart_valid,
    input  logic     uart_ready,
    output addr_t    sd_sector,
    output logic     sd_read_start,
    input  byte_t    sd_byte,
    input  logic     sd_byte_valid,
    output logic     sd_byte_ready
);

    logic                          sel_ram;
    logic                          sel_io;
    logic                          sel_none;
    logic [$clog2(RAM_WORDS)-1:0]  ram_index;
    logic [IO_OFF_W-1:0]           io_offset;
    data_t                         ram_rdata;
    logic                          ram_hit;
    data_t                         io_rdata;
    logic                          io_hit;

    region_decode #(
        .RAM_WORDS (RAM_WORDS)
    ) i_region_decode (
        .bus_address (bus_address),
        .sel_ram     (sel_ram),
        .sel_io      (sel_io),
        .sel_none    (sel_none),
        .ram_index   (ram_index),
        .io_offset   (io_offset)
    );

    ram_bank #(
        .RAM_WORDS (RAM_WORDS)
    ) i_ram_bank (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .sel_ram          (sel_ram),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .ram_index        (ram_index),
        .bus_write_data   (bus_write_data),
        .ram_rdata        (ram_rdata),
        .ram_hit          (ram_hit)
    );

    // Keyboard, UART and card registers plus the sector buffer
    periph_regs #(
        .SECTOR_BYTES (SECTOR_BYTES)
    ) i_periph_regs (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .sel_io           (sel_io),
        .io_offset        (io_offset),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .bus_write_data   (bus_write_data),
        .io_rdata         (io_rdata),
        .io_hit           (io_hit),
        .key_code         (key_code),
        .key_valid        (key_valid),
        .irq_ack          (irq_ack),
        .irq_vector       (irq_vector),
        .uart_data        (uart_data),
        .uart_valid       (uart_valid),
        .uart_ready       (uart_ready),
        .sd_sector        (sd_sector),
        .sd_read_start    (sd_read_start),
        .sd_byte          (sd_byte),
        .sd_byte_valid    (sd_byte_valid),
        .sd_byte_ready    (sd_byte_ready)
    );

    read_return i_read_return (
        .CLOCK_50        (CLOCK_50),
        .KEY0            (KEY0),
        .ram_rdata       (ram_rdata),
        .ram_hit         (ram_hit),
        .io_rdata        (io_rdata),
        .io_hit          (io_hit),
        .sel_none        (sel_none),
        .bus_read_enable (bus_read_enable),
        .bus_read_data   (bus_read_data),
        .bus_read_done   (bus_read_done)
    );

endmodule

// File: read_return.sv
module read_return
    import soc_pkg::*;
(
    input  logic  CLOCK_50,
    input  logic  KEY0,
    input  data_t ram_rdata,
    input  logic  ram_hit,
    input  data_t io_rdata,
    input  logic  io_hit,
    input  logic  sel_none,
    input  logic  bus_read_enable,
    output data_t bus_read_data,
    output logic  bus_read_done
);

    logic none_hit;

    // Unmapped marker lines up with the sides' one-cycle results
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            none_hit      <= 1'b0;
            bus_read_done <= 1'b0;
        end else begin
            none_hit      <= bus_read_enable && sel_none;
            bus_read_done <= ram_hit || io_hit || none_hit;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (ram_hit) begin
            bus_read_data <= ram_rdata;
        end else if (io_hit) begin
            bus_read_data <= io_rdata;
        end else if (none_hit) begin
            // Unmapped reads answer zero
            bus_read_data <= '0;
        end
    end

endmodule

// File: periph_regs.sv
module periph_regs
    import soc_pkg::*;
#(
    parameter int SECTOR_BYTES = SECTOR_BYTES_DEFAULT
) (
    input  logic                 CLOCK_50,
    input  logic                 KEY0,
    input  logic                 sel_io,
    input  logic [IO_OFF_W-1:0]  io_offset,
    input  logic                 bus_read_enable,
    input  logic                 bus_write_enable,
    input  data_t                bus_write_data,
    output data_t                io_rdata,
    output logic                 io_hit,
    input  byte_t                key_code,
    input  logic                 key_valid,
    input  logic                 irq_ack,
    output irq_vec_t             irq_vector,
    output byte_t                uart_data,
    output logic                 uart_valid,
    input  logic                 uart_ready,
    output addr_t                sd_sector,
    output logic                 sd_read_start,
    input  byte_t                sd_byte,
    input  logic                 sd_byte_valid,
    output logic                 sd_byte_ready
);

    localparam int IDX_W = $clog2(SECTOR_BYTES);

    // Register offsets within the peripheral window
    localparam logic [IO_OFF_W-1:0] OFF_KEY   = IO_OFF_W'(KEY_ADDR - IO_BASE);
    localparam logic [IO_OFF_W-1:0] OFF_UART  = IO_OFF_W'(UART_ADDR - IO_BASE);
    localparam logic [IO_OFF_W-1:0] OFF_SADDR = IO_OFF_W'(SD_ADDR_REG - IO_BASE);
    localparam logic [IO_OFF_W-1:0] OFF_SREAD = IO_OFF_W'(SD_READ_REG - IO_BASE);
    localparam logic [IO_OFF_W-1:0] OFF_AVAIL = IO_OFF_W'(SD_AVAIL_REG - IO_BASE);
    localparam logic [IO_OFF_W-1:0] OFF_BUF   = IO_OFF_W'(SD_BUF_BASE - IO_BASE);

    logic             wr_io;
    logic             in_buf;
    logic             key_valid_d;
    logic             key_edge;
    byte_t            key_latch;
    logic [IDX_W-1:0] buf_index;
    byte_t            buf_byte;
    logic             buf_full;
    logic             start_req;
    data_t            rd_mux;

    assign wr_io     = bus_write_enable && sel_io;
    assign start_req = wr_io && (io_offset == OFF_SREAD);
    assign in_buf    = (io_offset >= OFF_BUF) &&
                       (io_offset < OFF_BUF + IO_OFF_W'(SECTOR_BYTES));
    assign buf_index = IDX_W'(io_offset - OFF_BUF);
    assign key_edge  = key_valid && !key_valid_d;

    sector_buffer #(
        .SECTOR_BYTES (SECTOR_BYTES)
    ) i_sector_buffer (
        .CLOCK_50      (CLOCK_50),
        .KEY0          (KEY0),
        .read_start    (start_req),
        .sd_byte       (sd_byte),
        .sd_byte_valid (sd_byte_valid),
        .sd_byte_ready (sd_byte_ready),
        .buf_index     (buf_index),
        .buf_byte      (buf_byte),
        .buf_full      (buf_full)
    );

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            key_valid_d   <= 1'b0;
            key_latch     <= '0;
            irq_vector    <= '0;
            uart_valid    <= 1'b0;
            sd_sector     <= '0;
            sd_read_start <= 1'b0;
            io_hit        <= 1'b0;
        end else begin
            key_valid_d   <= key_valid;
            sd_read_start <= start_req;
            io_hit        <= bus_read_enable && sel_io;
            // Ack clears, but a fresh key press in the same cycle wins
            if (irq_ack && (irq_vector != '0)) begin
                irq_vector <= '0;
            end
            if (key_edge && (key_code != '0)) begin
                key_latch  <= key_code;
                irq_vector <= irq_vec_t'(1);
            end
            if (uart_valid && uart_ready) begin
                uart_valid <= 1'b0;
            end
            // Writes while a byte is pending are dropped
            if (wr_io && (io_offset == OFF_UART) && !uart_valid) begin
                uart_valid <= 1'b1;
            end
            if (wr_io && (io_offset == OFF_SADDR)) begin
                sd_sector <= bus_write_data[31:0];
            end
        end
    end

    // UART byte register, loaded when the port is free
    always_ff @(posedge CLOCK_50) begin
        if (wr_io && (io_offset == OFF_UART) && !uart_valid) begin
            uart_data <= bus_write_data[7:0];
        end
    end

    always_comb begin
        rd_mux = '0;
        if (in_buf) begin
            rd_mux = {56'd0, buf_byte};
        end else if (io_offset == OFF_KEY) begin
            rd_mux = {56'd0, key_latch};
        end else if (io_offset == OFF_SADDR) begin
            rd_mux = {32'd0, sd_sector};
        end else if (io_offset == OFF_AVAIL) begin
            rd_mux = {63'd0, buf_full};
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (bus_read_enable && sel_io) begin
            io_rdata <= rd_mux;
        end
    end

endmodule

// File: sector_buffer.sv
module sector_buffer
    import soc_pkg::*;
#(
    parameter int SECTOR_BYTES = SECTOR_BYTES_DEFAULT
) (
    input  logic                              CLOCK_50,
    input  logic                              KEY0,
    input  logic                              read_start,
    input  byte_t                             sd_byte,
    input  logic                              sd_byte_valid,
    output logic                              sd_byte_ready,
    input  logic [$clog2(SECTOR_BYTES)-1:0]   buf_index,
    output byte_t                             buf_byte,
    output logic                              buf_full
);

    localparam int IDX_W = $clog2(SECTOR_BYTES);

    byte_t            mem [SECTOR_BYTES];
    logic [IDX_W-1:0] fill_idx;
    logic             take;
    logic             last;

    // One byte per cycle when the stream and the buffer agree
    assign take = sd_byte_valid && sd_byte_ready;
    assign last = (fill_idx == IDX_W'(SECTOR_BYTES - 1));

    always_ff @(posedge CLOCK_50) begin
        if (take) begin
            mem[fill_idx] <= sd_byte;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            fill_idx      <= '0;
            sd_byte_ready <= 1'b0;
            buf_full      <= 1'b0;
        end else begin
            if (read_start) begin
                // Restart the fill from the first byte
                fill_idx      <= '0;
                sd_byte_ready <= 1'b1;
                buf_full      <= 1'b0;
            end else if (take) begin
                fill_idx <= fill_idx + IDX_W'(1);
                if (last) begin
                    sd_byte_ready <= 1'b0;
                    buf_full      <= 1'b1;
                end
            end
        end
    end

    // Read side is combinational, registered by the peripheral block
    assign buf_byte = mem[buf_index];

endmodule

// File: ram_bank.sv
module ram_bank
    import soc_pkg::*;
#(
    parameter int RAM_WORDS = RAM_WORDS_DEFAULT
) (
    input  logic                           CLOCK_50,
    input  logic                           KEY0,
    input  logic                           sel_ram,
    input  logic                           bus_read_enable,
    input  logic                           bus_write_enable,
    input  logic [$clog2(RAM_WORDS)-1:0]   ram_index,
    input  data_t                          bus_write_data,
    output data_t                          ram_rdata,
    output logic                           ram_hit
);

    logic [31:0] mem [RAM_WORDS];
    logic [31:0] rd_word;
    logic        rd_req;
    logic        wr_req;

    assign rd_req = bus_read_enable && sel_ram;
    assign wr_req = bus_write_enable && sel_ram;

    // Single read port and single write port, both on the clock edge
    always_ff @(posedge CLOCK_50) begin
        if (wr_req) begin
            // Only the low word is stored
            mem[ram_index] <= bus_write_data[31:0];
        end
        if (rd_req) begin
            rd_word <= mem[ram_index];
        end
    end

    // Hit flag follows the read by one cycle
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            ram_hit <= 1'b0;
        end else begin
            ram_hit <= rd_req;
        end
    end

    // Word is returned zero-extended to the bus width
    assign ram_rdata = {32'd0, rd_word};

endmodule

// File: region_decode.sv
module region_decode
    import soc_pkg::*;
#(
    parameter int RAM_WORDS = RAM_WORDS_DEFAULT
) (
    input  addr_t                          bus_address,
    output logic                           sel_ram,
    output logic                           sel_io,
    output logic                           sel_none,
    output logic [$clog2(RAM_WORDS)-1:0]   ram_index,
    output logic [IO_OFF_W-1:0]            io_offset
);

    localparam int    RAM_AW  = $clog2(RAM_WORDS);
    localparam addr_t RAM_END = RAM_BASE + addr_t'(RAM_WORDS * 4);
    localparam addr_t IO_END  = IO_BASE + IO_SPAN;

    addr_t ram_off;
    addr_t io_off;

    // Offsets relative to each window base
    assign ram_off = bus_address - RAM_BASE;
    assign io_off  = bus_address - IO_BASE;

    always_comb begin
        sel_ram = (bus_address >= RAM_BASE) && (bus_address < RAM_END);
        sel_io  = (bus_address >= IO_BASE) && (bus_address < IO_END);
        // Anything outside both windows answers zero
        sel_none = !sel_ram && !sel_io;
    end

    // Word index drops the byte lane bits
    assign ram_index = ram_off[RAM_AW+1:2];
    assign io_offset = io_off[IO_OFF_W-1:0];

endmodule

// File: soc_pkg.sv
package soc_pkg;

    // Bus and payload types
    typedef logic [31:0] addr_t;
    typedef logic [63:0] data_t;
    typedef logic [7:0]  byte_t;
    typedef logic [3:0]  irq_vec_t;

    // RAM window
    localparam addr_t RAM_BASE          = 32'h0000_1000;
    localparam int    RAM_WORDS_DEFAULT = 1024;

    // Peripheral window
    localparam addr_t IO_BASE  = 32'h8000_0000;
    localparam addr_t IO_SPAN  = 32'h0000_2000;
    localparam int    IO_OFF_W = 13;

    // Register addresses inside the peripheral window
    localparam addr_t KEY_ADDR     = 32'h8000_0000;
    localparam addr_t UART_ADDR    = 32'h8000_0008;
    localparam addr_t SD_ADDR_REG  = 32'h8000_0010;
    localparam addr_t SD_READ_REG  = 32'h8000_0018;
    localparam addr_t SD_AVAIL_REG = 32'h8000_0020;
    localparam addr_t SD_BUF_BASE  = 32'h8000_1000;

    // One card sector
    localparam int SECTOR_BYTES_DEFAULT = 512;

endpackage
